//--- build.f
rtl/llc_cfg_pkg.sv
rtl/llc_msg_pkg.sv
rtl/llc_input_arbiter.sv
rtl/llc_read_set.sv
rtl/llc_stall_regs.sv
rtl/llc_front_end.sv
test/llc_front_end_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -f build.f --top-module llc_front_end_tb -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log
grep -qx "TESTS PASSED" sim.log && exit 0 || exit 1

//--- test/llc_front_end_tests.txt
# rnd rsp_v rsp_a req_v req_a dma_v dma_a resume flush conflict | check_mask
# served set rst_stall flush_stall req_stall dma_addr (all hex)
0 0 000 1 123 0 000 0 0 0 3f 2 1 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 2 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 3 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 4 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 5 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 6 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 7 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 8 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 9 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 a 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 b 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 c 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 d 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 e 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 f 1 0 0 000
0 0 000 1 123 0 000 0 0 0 3f 2 0 1 0 0 000
0 0 000 1 123 1 400 0 0 0 3f 3 0 0 0 0 000
0 1 456 1 124 1 400 0 0 1 3f 1 3 0 0 0 000
0 0 000 1 124 1 400 0 0 0 3f 4 6 0 0 1 000
0 1 124 1 124 0 000 0 0 0 3f 1 0 0 0 1 400
0 1 123 1 124 0 000 0 0 0 3f 1 4 0 0 1 400
0 0 000 1 124 0 000 1 0 0 3f 3 3 0 0 0 400
0 0 000 0 000 0 000 1 0 0 3f 5 4 0 0 0 400
0 0 000 0 000 1 500 1 0 0 3f 4 1 0 0 0 401
0 0 000 0 000 0 000 1 0 0 3f 5 0 0 0 0 500
0 0 000 0 000 0 000 1 1 0 3f 5 1 0 0 0 501
0 0 000 0 000 1 600 1 0 0 3f 2 1 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 2 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 3 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 4 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 5 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 6 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 7 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 8 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 9 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 a 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 b 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 c 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 d 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 e 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 f 0 1 0 502
0 0 000 0 000 1 600 1 0 0 3f 2 0 0 1 0 502
0 0 000 0 000 1 600 0 0 0 3f 4 0 0 0 0 502
1 1 000 0 000 0 000 0 0 0 3f 1 0 0 0 0 600
2 0 000 1 000 0 000 0 0 0 01 3 0 0 0 0 000
3 1 000 1 000 0 000 0 0 0 01 1 0 0 0 0 000
0 0 000 0 000 0 000 0 0 0 3d 0 0 0 0 0 600

//--- test/llc_front_end_tb.sv
module llc_front_end_tb
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NCOL = 17;

    logic                      clk;
    logic                      rst;
    logic                      rsp_valid;
    logic [LINE_ADDR_BITS-1:0] rsp_addr;
    logic                      req_valid;
    logic [LINE_ADDR_BITS-1:0] req_addr;
    logic                      dma_req_valid;
    logic [LINE_ADDR_BITS-1:0] dma_req_addr;
    logic                      dma_resume_pending;
    logic                      flush_start;
    logic                      req_conflict;
    src_t                      served;
    logic [LLC_SET_BITS-1:0]   set;
    logic [LLC_SET_BITS-1:0]   set_next;
    logic [TAG_BITS-1:0]       line_tag;
    logic [LLC_SET_BITS-1:0]   line_set;
    logic                      rst_stall;
    logic                      flush_stall;
    logic                      req_stall;
    logic [LINE_ADDR_BITS-1:0] dma_addr;

    int          tv[$];
    int          n_vec = 0;
    logic [15:0] lfsr = 16'd12312;

    llc_front_end i_llc_front_end (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function int random_line_addr();
        int a;
        a = 0;
        for (int i = 0; i < LINE_ADDR_BITS; i++) begin
            lfsr = lfsr_step(lfsr);
            a = (a << 1) | int'(lfsr[0]);
        end
        return a;
    endfunction

    task automatic check(string name, int got, int exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic read_vectors();
        int    fd;
        string line;
        int    f[NCOL];
        fd = $fopen("test/llc_front_end_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test vector file");
            $display("TESTS FAILED");
            $fatal(1, "missing vectors");
        end
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]) == NCOL) begin
                foreach (f[i]) tv.push_back(f[i]);
            end
        end
        $fclose(fd);
        n_vec = tv.size() / NCOL;
    endtask

    initial begin
        wait (n_vec > 0);
        #(n_vec * 10 + 200);
        $display("Timeout, the vectors did not finish in time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        int b;
        int chk;
        int rsp_a;
        int req_a;
        int dma_a;
        int pend_addr;
        bit pending;
        rst = 1'b0;
        rsp_valid = 1'b0;
        rsp_addr = '0;
        req_valid = 1'b0;
        req_addr = '0;
        dma_req_valid = 1'b0;
        dma_req_addr = '0;
        dma_resume_pending = 1'b0;
        flush_start = 1'b0;
        req_conflict = 1'b0;
        pending = 1'b0;
        pend_addr = 0;
        read_vectors();
        if (n_vec == 0) begin
            $display("The test vector file holds no vectors");
            $display("TESTS FAILED");
            $fatal(1, "no vectors");
        end
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            b = i * NCOL;
            rsp_a = (tv[b] & 1) ? random_line_addr() : tv[b+2];
            req_a = (tv[b] & 2) ? random_line_addr() : tv[b+4];
            dma_a = (tv[b] & 4) ? random_line_addr() : tv[b+6];
            rsp_valid          <= tv[b+1] != 0;
            rsp_addr           <= LINE_ADDR_BITS'(rsp_a);
            req_valid          <= tv[b+3] != 0;
            req_addr           <= LINE_ADDR_BITS'(req_a);
            dma_req_valid      <= tv[b+5] != 0;
            dma_req_addr       <= LINE_ADDR_BITS'(dma_a);
            dma_resume_pending <= tv[b+7] != 0;
            flush_start        <= tv[b+8] != 0;
            req_conflict       <= tv[b+9] != 0;
            @(negedge clk);
            // Breakdown of the address served in the previous cycle
            if (pending) begin
                check("line_set", int'(line_set), pend_addr % 16);
                check("line_tag", int'(line_tag), (pend_addr >> 4) & 'hff);
                pending = 1'b0;
            end
            chk = tv[b+10];
            if (chk & 'h01) check("served", int'(served), tv[b+11]);
            if (chk & 'h02) check("set", int'(set), tv[b+12]);
            if (chk & 'h04) check("rst_stall", int'(rst_stall), tv[b+13]);
            if (chk & 'h08) check("flush_stall", int'(flush_stall), tv[b+14]);
            if (chk & 'h10) check("req_stall", int'(req_stall), tv[b+15]);
            if (chk & 'h20) check("dma_addr", int'(dma_addr), tv[b+16]);
            if (chk & 'h01) begin
                pending = 1'b1;
                case (tv[b+11])
                    1: pend_addr = rsp_a;
                    3: pend_addr = req_a;
                    4: pend_addr = dma_a;
                    // Resume serves the line after the current DMA address
                    5: begin
                        pend_addr = tv[b+16] + 1;
                        pending   = (chk & 'h20) != 0;
                    end
                    default: pending = 1'b0;
                endcase
                if (pending) begin
                    check("set_next", int'(set_next), pend_addr % 16);
                end else if (tv[b+11] == 2 && (chk & 'h02)) begin
                    check("set_next", int'(set_next), tv[b+12]);
                end
            end
            @(posedge clk);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- rtl/llc_front_end.sv
module llc_front_end
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rsp_valid,
    input  logic [LINE_ADDR_BITS-1:0] rsp_addr,
    input  logic                      req_valid,
    input  logic [LINE_ADDR_BITS-1:0] req_addr,
    input  logic                      dma_req_valid,
    input  logic [LINE_ADDR_BITS-1:0] dma_req_addr,
    input  logic                      dma_resume_pending,
    input  logic                      flush_start,
    input  logic                      req_conflict,
    output src_t                      served,
    output logic [LLC_SET_BITS-1:0]   set,
    output logic [LLC_SET_BITS-1:0]   set_next,
    output logic [TAG_BITS-1:0]       line_tag,
    output logic [LLC_SET_BITS-1:0]   line_set,
    output logic                      rst_stall,
    output logic                      flush_stall,
    output logic                      req_stall,
    output logic [LINE_ADDR_BITS-1:0] dma_addr
);

    logic                    is_rsp_to_get;
    logic                    is_walk;
    logic                    is_req_to_get;
    logic                    is_dma_req_to_get;
    logic                    is_dma_resume;
    logic                    rd_set_en;
    logic                    incr_walk_set;
    logic                    clr_walk_stall;
    logic                    clr_req_stall;
    logic                    load_dma_addr;
    logic [LLC_SET_BITS-1:0] walk_set;
    logic [LLC_SET_BITS-1:0] stalled_set;
    logic [TAG_BITS-1:0]     stalled_tag;

    llc_input_arbiter i_llc_input_arbiter (
        .rsp_valid          (rsp_valid),
        .req_valid          (req_valid),
        .dma_req_valid      (dma_req_valid),
        .dma_resume_pending (dma_resume_pending),
        .rst_stall          (rst_stall),
        .flush_stall        (flush_stall),
        .req_stall          (req_stall),
        .is_rsp_to_get      (is_rsp_to_get),
        .is_walk            (is_walk),
        .is_req_to_get      (is_req_to_get),
        .is_dma_req_to_get  (is_dma_req_to_get),
        .is_dma_resume      (is_dma_resume),
        .rd_set_en          (rd_set_en),
        .served             (served)
    );

    llc_read_set i_llc_read_set (
        .clk               (clk),
        .rst               (rst),
        .rd_set_en         (rd_set_en),
        .is_rsp_to_get     (is_rsp_to_get),
        .is_walk           (is_walk),
        .is_req_to_get     (is_req_to_get),
        .is_dma_req_to_get (is_dma_req_to_get),
        .is_dma_resume     (is_dma_resume),
        .rsp_addr          (rsp_addr),
        .req_addr          (req_addr),
        .dma_req_addr      (dma_req_addr),
        .dma_addr          (dma_addr),
        .walk_set          (walk_set),
        .stalled_set       (stalled_set),
        .stalled_tag       (stalled_tag),
        .req_stall         (req_stall),
        .set               (set),
        .set_next          (set_next),
        .line_tag          (line_tag),
        .line_set          (line_set),
        .incr_walk_set     (incr_walk_set),
        .clr_walk_stall    (clr_walk_stall),
        .clr_req_stall     (clr_req_stall),
        .load_dma_addr     (load_dma_addr)
    );

    llc_stall_regs i_llc_stall_regs (
        .clk            (clk),
        .rst            (rst),
        .flush_start    (flush_start),
        .req_conflict   (req_conflict),
        .incr_walk_set  (incr_walk_set),
        .clr_walk_stall (clr_walk_stall),
        .clr_req_stall  (clr_req_stall),
        .load_dma_addr  (load_dma_addr),
        .is_dma_resume  (is_dma_resume),
        .dma_req_addr   (dma_req_addr),
        .line_tag       (line_tag),
        .line_set       (line_set),
        .walk_set       (walk_set),
        .rst_stall      (rst_stall),
        .flush_stall    (flush_stall),
        .req_stall      (req_stall),
        .stalled_set    (stalled_set),
        .stalled_tag    (stalled_tag),
        .dma_addr       (dma_addr)
    );

endmodule

//--- rtl/llc_stall_regs.sv
module llc_stall_regs
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush_start,
    input  logic                      req_conflict,
    input  logic                      incr_walk_set,
    input  logic                      clr_walk_stall,
    input  logic                      clr_req_stall,
    input  logic                      load_dma_addr,
    input  logic                      is_dma_resume,
    input  logic [LINE_ADDR_BITS-1:0] dma_req_addr,
    input  logic [TAG_BITS-1:0]       line_tag,
    input  logic [LLC_SET_BITS-1:0]   line_set,
    output logic [LLC_SET_BITS-1:0]   walk_set,
    output logic                      rst_stall,
    output logic                      flush_stall,
    output logic                      req_stall,
    output logic [LLC_SET_BITS-1:0]   stalled_set,
    output logic [TAG_BITS-1:0]       stalled_tag,
    output logic [LINE_ADDR_BITS-1:0] dma_addr
);

    walk_t walk_mode;

    // Reset starts a full walk; a flush is only taken once idle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            walk_mode <= WALK_RST;
            walk_set  <= '0;
        end else if (clr_walk_stall) begin
            walk_mode <= flush_start ? WALK_FLUSH : WALK_IDLE;
            walk_set  <= '0;
        end else begin
            if (flush_start && walk_mode == WALK_IDLE) begin
                walk_mode <= WALK_FLUSH;
            end
            if (incr_walk_set) begin
                walk_set <= walk_set + 1'b1;
            end
        end
    end

    assign rst_stall   = (walk_mode == WALK_RST);
    assign flush_stall = (walk_mode == WALK_FLUSH);

    // Conflict refers to the request served last cycle, whose breakdown is now registered
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall <= 1'b0;
        end else if (req_conflict) begin
            req_stall <= 1'b1;
        end else if (clr_req_stall) begin
            req_stall <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_conflict) begin
            stalled_tag <= line_tag;
            stalled_set <= line_set;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_addr <= '0;
        end else if (load_dma_addr) begin
            dma_addr <= dma_req_addr;
        end else if (is_dma_resume) begin
            dma_addr <= dma_addr + 1'b1;
        end
    end

    // Counter only moves inside a walk and is back at zero when one ends
    a_walk_set_idle_zero: assert property (
        @(posedge clk) disable iff (!rst)
        !(rst_stall || flush_stall) |-> walk_set == '0
    ) else $error("walk counter not at zero outside a walk");

endmodule

//--- rtl/llc_read_set.sv
module llc_read_set
    import llc_cfg_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_set_en,
    input  logic                      is_rsp_to_get,
    input  logic                      is_walk,
    input  logic                      is_req_to_get,
    input  logic                      is_dma_req_to_get,
    input  logic                      is_dma_resume,
    input  logic [LINE_ADDR_BITS-1:0] rsp_addr,
    input  logic [LINE_ADDR_BITS-1:0] req_addr,
    input  logic [LINE_ADDR_BITS-1:0] dma_req_addr,
    input  logic [LINE_ADDR_BITS-1:0] dma_addr,
    input  logic [LLC_SET_BITS-1:0]   walk_set,
    input  logic [LLC_SET_BITS-1:0]   stalled_set,
    input  logic [TAG_BITS-1:0]       stalled_tag,
    input  logic                      req_stall,
    output logic [LLC_SET_BITS-1:0]   set,
    output logic [LLC_SET_BITS-1:0]   set_next,
    output logic [TAG_BITS-1:0]       line_tag,
    output logic [LLC_SET_BITS-1:0]   line_set,
    output logic                      incr_walk_set,
    output logic                      clr_walk_stall,
    output logic                      clr_req_stall,
    output logic                      load_dma_addr
);

    logic [LINE_ADDR_BITS-1:0] addr_for_set;
    logic [TAG_BITS-1:0]       tag_next;
    logic [LLC_SET_BITS-1:0]   set_from_addr;
    logic [LLC_SET_BITS-1:0]   walk_set_incr;

    always_comb begin
        addr_for_set  = '0;
        load_dma_addr = 1'b0;
        if (is_rsp_to_get) begin
            addr_for_set = rsp_addr;
        end else if (is_req_to_get) begin
            addr_for_set = req_addr;
        end else if (is_dma_req_to_get) begin
            addr_for_set  = dma_req_addr;
            load_dma_addr = 1'b1;
        end else if (is_dma_resume) begin
            // Burst continues at the line after the last one served
            addr_for_set = dma_addr + 1'b1;
        end
    end

    assign tag_next      = addr_for_set[LINE_ADDR_BITS-1:LLC_SET_BITS];
    assign set_from_addr = addr_for_set[LLC_SET_BITS-1:0];

    assign incr_walk_set  = is_walk;
    assign clr_walk_stall = is_walk && (walk_set == '1);

    // A response to the stalled line lets the request retry
    assign clr_req_stall = is_rsp_to_get && req_stall
                        && (tag_next == stalled_tag)
                        && (set_from_addr == stalled_set);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_tag <= '0;
            line_set <= '0;
        end else if (rd_set_en) begin
            line_tag <= tag_next;
            line_set <= set_from_addr;
        end
    end

    // Walk overrides the set index with the counter one step ahead
    assign walk_set_incr = walk_set + 1'b1;
    assign set_next      = is_walk ? walk_set_incr : set_from_addr;
    assign set           = is_walk ? walk_set_incr : line_set;

    a_clr_req_only_on_rsp: assert property (
        @(posedge clk) disable iff (!rst)
        clr_req_stall |=> {line_tag, line_set} == $past(rsp_addr)
    ) else $error("request stall cleared without the response line being registered");

endmodule

//--- rtl/llc_input_arbiter.sv
module llc_input_arbiter
    import llc_msg_pkg::*;
(
    input  logic rsp_valid,
    input  logic req_valid,
    input  logic dma_req_valid,
    input  logic dma_resume_pending,
    input  logic rst_stall,
    input  logic flush_stall,
    input  logic req_stall,
    output logic is_rsp_to_get,
    output logic is_walk,
    output logic is_req_to_get,
    output logic is_dma_req_to_get,
    output logic is_dma_resume,
    output logic rd_set_en,
    output src_t served
);

    logic walk_active;
    logic req_ready;

    assign walk_active = rst_stall || flush_stall;
    assign req_ready   = req_valid && !req_stall;

    // Responses never wait since they free resources held by the walk and by stalled requests
    assign is_rsp_to_get     = rsp_valid;
    assign is_walk           = !rsp_valid && walk_active;
    assign is_req_to_get     = !rsp_valid && !walk_active && req_ready;
    assign is_dma_req_to_get = !rsp_valid && !walk_active && !req_ready && dma_req_valid;
    assign is_dma_resume     = !rsp_valid && !walk_active && !req_ready && !dma_req_valid
                             && dma_resume_pending;

    always_comb begin
        case (1'b1)
            is_rsp_to_get:     served = SRC_RSP;
            is_walk:           served = SRC_WALK;
            is_req_to_get:     served = SRC_REQ;
            is_dma_req_to_get: served = SRC_DMA_REQ;
            is_dma_resume:     served = SRC_DMA_RESUME;
            default:           served = SRC_NONE;
        endcase
    end

    // Any served source reads a set this cycle
    assign rd_set_en = is_rsp_to_get | is_walk | is_req_to_get
                     | is_dma_req_to_get | is_dma_resume;

    // Downstream logic relies on at most one strobe per cycle
    always_comb begin
        assert ($onehot0({is_rsp_to_get, is_walk, is_req_to_get,
                          is_dma_req_to_get, is_dma_resume}))
        else $error("more than one input served in a cycle");
    end

endmodule

//--- rtl/llc_msg_pkg.sv
package llc_msg_pkg;

    // Source served in the current cycle
    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_RSP,
        SRC_WALK,
        SRC_REQ,
        SRC_DMA_REQ,
        SRC_DMA_RESUME
    } src_t;

    // Walk over all sets, either after reset or for a flush
    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_RST,
        WALK_FLUSH
    } walk_t;

endpackage

//--- rtl/llc_cfg_pkg.sv
package llc_cfg_pkg;

    // Byte address as seen by the controller
    localparam int ADDR_BITS = 16;

    // 16-byte lines
    localparam int OFFSET_BITS = 4;

    // Line address, which is what every input carries
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    // 16 sets
    localparam int LLC_SET_BITS = 4;

    // Tag sits above the set index in the line address
    localparam int TAG_BITS = LINE_ADDR_BITS - LLC_SET_BITS;

endpackage
